// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // datapath widths.
    localparam int data_width = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs = 32;

    // byte offset between sequential instructions.
    localparam int inst_bytes = 4;

    // data, pc and target values.
    typedef logic [data_width-1:0] word_t;

    // register index.
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // writeback source select, as decoded upstream.
    typedef enum logic [2:0] {
        wb_alu   = 3'd0, // alu result, also the fallback.
        wb_memb  = 3'd1, // signed byte load.
        wb_membu = 3'd2, // unsigned byte load.
        wb_memh  = 3'd3, // signed halfword load.
        wb_memhu = 3'd4, // unsigned halfword load.
        wb_memw  = 3'd5, // word load.
        wb_pc    = 3'd6, // link address.
        wb_csr   = 3'd7  // csr read data.
    } wb_sel_t;

    // stack pointer value after reset.
    localparam word_t sp_reset_default = 32'd1000;

    // x2 is the stack pointer in the standard abi.
    localparam int sp_index = 2;

endpackage

`default_nettype wire

// ==== logic/wb_input_latch.sv ====
`default_nettype none

module wb_input_latch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  core_pkg::word_t     pc,
    input  core_pkg::wb_sel_t   wb_sel,
    input  core_pkg::reg_addr_t rd_addr,
    input  logic               rf_wen,
    input  logic               br_flg,
    input  core_pkg::word_t     br_target,
    input  logic               jmp_flg,
    input  core_pkg::word_t     alu_out,
    input  core_pkg::word_t     csr_rdata,
    input  core_pkg::word_t     mem_rdata,
    input  logic               is_ecall,
    input  core_pkg::word_t     trap_vector,
    input  logic               retire,
    output logic               held_valid,
    output core_pkg::word_t     held_pc,
    output core_pkg::wb_sel_t   held_wb_sel,
    output core_pkg::reg_addr_t held_rd_addr,
    output logic               held_rf_wen,
    output logic               held_br_flg,
    output core_pkg::word_t     held_br_target,
    output logic               held_jmp_flg,
    output core_pkg::word_t     held_alu_out,
    output core_pkg::word_t     held_csr_rdata,
    output core_pkg::word_t     held_mem_rdata,
    output logic               held_is_ecall,
    output core_pkg::word_t     held_trap_vector
);

    logic accept;

    // free slot, or the slot drains this cycle.
    assign in_ready = !held_valid || retire;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (accept) begin
            held_valid <= 1'b1;
        end else if (retire) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_pc          <= pc;
            held_wb_sel      <= wb_sel;
            held_rd_addr     <= rd_addr;
            held_rf_wen      <= rf_wen;
            held_br_flg      <= br_flg;
            held_br_target   <= br_target;
            held_jmp_flg     <= jmp_flg;
            held_alu_out     <= alu_out;
            held_csr_rdata   <= csr_rdata;
            held_mem_rdata   <= mem_rdata;
            held_is_ecall    <= is_ecall;
            held_trap_vector <= trap_vector;
        end
    end

    // a stalled offer must not change under us.
    a_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable({pc, wb_sel, rd_addr, rf_wen,
            br_flg, br_target, jmp_flg, alu_out, csr_rdata, mem_rdata, is_ecall,
            trap_vector}))
        else $error("instruction fields changed while stalled");

endmodule

`default_nettype wire

// ==== logic/wb_stage.sv ====
`default_nettype none

module wb_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               held_valid,
    input  core_pkg::word_t     held_pc,
    input  core_pkg::wb_sel_t   held_wb_sel,
    input  core_pkg::reg_addr_t held_rd_addr,
    input  logic               held_rf_wen,
    input  logic               held_br_flg,
    input  core_pkg::word_t     held_br_target,
    input  logic               held_jmp_flg,
    input  core_pkg::word_t     held_alu_out,
    input  core_pkg::word_t     held_csr_rdata,
    input  core_pkg::word_t     held_mem_rdata,
    input  logic               held_is_ecall,
    input  core_pkg::word_t     held_trap_vector,
    input  logic               next_pc_ready,
    output logic               next_pc_valid,
    output core_pkg::word_t     next_pc,
    output logic               branch_hazard,
    output logic               retire,
    output logic               wr_en,
    output core_pkg::reg_addr_t wr_addr,
    output core_pkg::word_t     wr_data
);

    core_pkg::word_t pc_plus4;
    core_pkg::word_t wb_data;

    assign pc_plus4 = held_pc + core_pkg::word_t'(core_pkg::inst_bytes);

    // pick the value that goes back to rd.
    always_comb begin
        case (held_wb_sel)
            core_pkg::wb_memb: begin
                wb_data = {{24{held_mem_rdata[7]}}, held_mem_rdata[7:0]};
            end
            core_pkg::wb_membu: begin
                wb_data = {24'b0, held_mem_rdata[7:0]};
            end
            core_pkg::wb_memh: begin
                wb_data = {{16{held_mem_rdata[15]}}, held_mem_rdata[15:0]};
            end
            core_pkg::wb_memhu: begin
                wb_data = {16'b0, held_mem_rdata[15:0]};
            end
            core_pkg::wb_memw: begin
                wb_data = held_mem_rdata;
            end
            core_pkg::wb_pc: begin
                wb_data = pc_plus4; // link address.
            end
            core_pkg::wb_csr: begin
                wb_data = held_csr_rdata;
            end
            default: begin
                wb_data = held_alu_out;
            end
        endcase
    end

    // branch wins over jump, jump over ecall.
    always_comb begin
        if (held_br_flg) begin
            next_pc = held_br_target;
        end else if (held_jmp_flg) begin
            next_pc = held_alu_out; // jal/jalr target from the alu.
        end else if (held_is_ecall) begin
            next_pc = held_trap_vector;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // fetch has to flush on any redirect.
    assign branch_hazard = held_br_flg || held_jmp_flg || held_is_ecall;

    assign next_pc_valid = held_valid;
    assign retire        = next_pc_valid && next_pc_ready;

    // register write lands on the retiring edge only.
    assign wr_en   = retire && held_rf_wen;
    assign wr_addr = held_rd_addr;
    assign wr_data = wb_data;

    // an offered pc stays put until fetch takes it.
    a_next_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        next_pc_valid && !next_pc_ready |=> next_pc_valid && $stable(next_pc))
        else $error("next_pc changed before it was accepted");

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file #(
    parameter core_pkg::word_t sp_reset = core_pkg::sp_reset_default
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data,
    input  core_pkg::reg_addr_t rs_addr,
    output core_pkg::word_t     rs_data
);

    core_pkg::word_t regs [core_pkg::num_regs];

    // reset loads the abi start state, x2 gets the stack top.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < core_pkg::num_regs; i++) begin
                if (i == core_pkg::sp_index) begin
                    regs[i] <= sp_reset;
                end else begin
                    regs[i] <= '0;
                end
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data; // x0 writes dropped.
        end
    end

    // read is combinational. x0 is hardwired.
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

    // entry 0 must stay zero across every write sequence.
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0)
        else $error("x0 storage became nonzero");

endmodule

`default_nettype wire

// ==== logic/writeback_top.sv ====
`default_nettype none

module writeback_top #(
    parameter core_pkg::word_t sp_reset = core_pkg::sp_reset_default
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  core_pkg::word_t     pc,
    input  core_pkg::wb_sel_t   wb_sel,
    input  core_pkg::reg_addr_t rd_addr,
    input  logic               rf_wen,
    input  logic               br_flg,
    input  core_pkg::word_t     br_target,
    input  logic               jmp_flg,
    input  core_pkg::word_t     alu_out,
    input  core_pkg::word_t     csr_rdata,
    input  core_pkg::word_t     mem_rdata,
    input  logic               is_ecall,
    input  core_pkg::word_t     trap_vector,
    output logic               next_pc_valid,
    input  logic               next_pc_ready,
    output core_pkg::word_t     next_pc,
    output logic               branch_hazard,
    input  core_pkg::reg_addr_t rs_addr,
    output core_pkg::word_t     rs_data
);

    logic                held_valid;
    core_pkg::word_t     held_pc;
    core_pkg::wb_sel_t   held_wb_sel;
    core_pkg::reg_addr_t held_rd_addr;
    logic                held_rf_wen;
    logic                held_br_flg;
    core_pkg::word_t     held_br_target;
    logic                held_jmp_flg;
    core_pkg::word_t     held_alu_out;
    core_pkg::word_t     held_csr_rdata;
    core_pkg::word_t     held_mem_rdata;
    logic                held_is_ecall;
    core_pkg::word_t     held_trap_vector;
    logic                retire;
    logic                wr_en;
    core_pkg::reg_addr_t wr_addr;
    core_pkg::word_t     wr_data;

    wb_input_latch i_wb_input_latch (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready),
        .pc(pc), .wb_sel(wb_sel), .rd_addr(rd_addr), .rf_wen(rf_wen),
        .br_flg(br_flg), .br_target(br_target), .jmp_flg(jmp_flg),
        .alu_out(alu_out), .csr_rdata(csr_rdata), .mem_rdata(mem_rdata),
        .is_ecall(is_ecall), .trap_vector(trap_vector),
        .retire(retire), .held_valid(held_valid),
        .held_pc(held_pc), .held_wb_sel(held_wb_sel), .held_rd_addr(held_rd_addr),
        .held_rf_wen(held_rf_wen), .held_br_flg(held_br_flg),
        .held_br_target(held_br_target), .held_jmp_flg(held_jmp_flg),
        .held_alu_out(held_alu_out), .held_csr_rdata(held_csr_rdata),
        .held_mem_rdata(held_mem_rdata), .held_is_ecall(held_is_ecall),
        .held_trap_vector(held_trap_vector)
    );

    wb_stage i_wb_stage (
        .clk(clk), .rst_n(rst_n),
        .held_valid(held_valid),
        .held_pc(held_pc), .held_wb_sel(held_wb_sel), .held_rd_addr(held_rd_addr),
        .held_rf_wen(held_rf_wen), .held_br_flg(held_br_flg),
        .held_br_target(held_br_target), .held_jmp_flg(held_jmp_flg),
        .held_alu_out(held_alu_out), .held_csr_rdata(held_csr_rdata),
        .held_mem_rdata(held_mem_rdata), .held_is_ecall(held_is_ecall),
        .held_trap_vector(held_trap_vector),
        .next_pc_ready(next_pc_ready), .next_pc_valid(next_pc_valid),
        .next_pc(next_pc), .branch_hazard(branch_hazard), .retire(retire),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    reg_file #(
        .sp_reset(sp_reset)
    ) i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rs_addr(rs_addr), .rs_data(rs_data)
    );

endmodule

`default_nettype wire

// ==== dv/tb_writeback_top.sv ====
`default_nettype none

module tb_writeback_top;

    localparam int cycles_per_line = 40;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    logic                in_ready;
    core_pkg::word_t     pc;
    core_pkg::wb_sel_t   wb_sel;
    core_pkg::reg_addr_t rd_addr;
    logic                rf_wen;
    logic                br_flg;
    core_pkg::word_t     br_target;
    logic                jmp_flg;
    core_pkg::word_t     alu_out;
    core_pkg::word_t     csr_rdata;
    core_pkg::word_t     mem_rdata;
    logic                is_ecall;
    core_pkg::word_t     trap_vector;
    logic                next_pc_valid;
    logic                next_pc_ready;
    core_pkg::word_t     next_pc;
    logic                branch_hazard;
    core_pkg::reg_addr_t rs_addr;
    core_pkg::word_t     rs_data;

    string trace_lines[$];
    int    seed = 8166;
    int    cycle_cnt = 0;
    int    cycle_limit = 100; // raised once the trace is read.
    int    retire_cnt = 0;
    int    instr_cnt = 0;
    int    test_num = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    test_errs = 0;
    logic  trace_ok;

    // fields of the current trace line.
    logic [31:0] v_pc, v_sel, v_rd, v_wen, v_br, v_brt, v_jmp, v_alu;
    logic [31:0] v_csr, v_mem, v_ecall, v_trap, v_next, v_haz, v_val;
    int          v_stall;

    writeback_top i_writeback_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n && next_pc_valid && next_pc_ready) begin
            retire_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("run stopped after %0d cycles without finishing the trace", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_word(input string name, input core_pkg::word_t got,
                                input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic compare_reg(input core_pkg::reg_addr_t idx, input core_pkg::word_t got,
                               input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] rs_data x%0d got 0x%08h expected 0x%08h", idx, got, exp);
            test_errs++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        test_errs++;
    endtask

    task automatic finish_test(input string what);
        test_num++;
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0d %s: ok", test_num, what);
        end else begin
            fail_cnt++;
            $display("test %0d %s: failed with %0d errors", test_num, what, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen("dv/wb_trace.txt", "r");
        trace_ok = (fd != 0);
        if (trace_ok) begin
            while ($fgets(line, fd) != 0) begin
                // blank and comment lines carry no test.
                if (line.len() > 1 && line.getc(0) != "#" && line.getc(0) != " ") begin
                    trace_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic read_reg(input core_pkg::reg_addr_t idx, output core_pkg::word_t val);
        @(negedge clk);
        rs_addr = idx;
        #1;
        val = rs_data;
    endtask

    task automatic run_instr();
        core_pkg::word_t old_val;
        int              waited;
        int              r;
        logic            done;
        @(negedge clk);
        pc          = v_pc;
        wb_sel      = core_pkg::wb_sel_t'(v_sel[2:0]);
        rd_addr     = v_rd[4:0];
        rf_wen      = v_wen[0];
        br_flg      = v_br[0];
        br_target   = v_brt;
        jmp_flg     = v_jmp[0];
        alu_out     = v_alu;
        csr_rdata   = v_csr;
        mem_rdata   = v_mem;
        is_ecall    = v_ecall[0];
        trap_vector = v_trap;
        in_valid    = 1'b1;
        next_pc_ready = 1'b0;
        rs_addr     = v_rd[4:0]; // watch the target across the stall.
        #1;
        old_val = rs_data;
        waited = 0;
        while (!in_ready && waited < 10) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!in_ready) begin
            report_error("the instruction was never accepted, in_ready stayed low");
            in_valid = 1'b0;
        end else begin
            done = 1'b0;
            for (int c = 0; c < v_stall + 30 && !done; c++) begin
                @(negedge clk);
                in_valid = 1'b0;
                if (c < v_stall) begin
                    next_pc_ready = 1'b0;
                end else begin
                    r = $random(seed);
                    next_pc_ready = ($unsigned(r) % 3) != 0; // high two times in three.
                end
                #1;
                compare_flag("next_pc_valid", next_pc_valid, 1'b1);
                compare_word("next_pc", next_pc, v_next);
                compare_flag("branch_hazard", branch_hazard, v_haz[0]);
                compare_flag("in_ready", in_ready, next_pc_ready);
                if (!next_pc_ready) begin
                    compare_reg(v_rd[4:0], rs_data, old_val);
                end
                done = next_pc_ready;
            end
            if (!done) begin
                report_error("the instruction never retired on the next-pc handshake");
            end
            @(negedge clk);
            next_pc_ready = 1'b0;
            #1;
            compare_flag("next_pc_valid", next_pc_valid, 1'b0);
        end
    endtask

    initial begin
        string tag;
        int    n;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        pc = '0;
        wb_sel = core_pkg::wb_alu;
        rd_addr = '0;
        rf_wen = 1'b0;
        br_flg = 1'b0;
        br_target = '0;
        jmp_flg = 1'b0;
        alu_out = '0;
        csr_rdata = '0;
        mem_rdata = '0;
        is_ecall = 1'b0;
        trap_vector = '0;
        next_pc_ready = 1'b0;
        rs_addr = '0;
        load_trace();
        cycle_limit = trace_lines.size() * cycles_per_line + 100;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        if (!trace_ok) begin
            $display("could not open dv/wb_trace.txt");
            fail_cnt++;
        end else begin
            foreach (trace_lines[i]) begin
                n = $sscanf(trace_lines[i], "%s", tag);
                if (tag == "I") begin
                    n = $sscanf(trace_lines[i],
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d", tag, v_pc, v_sel,
                        v_rd, v_wen, v_br, v_brt, v_jmp, v_alu, v_csr, v_mem, v_ecall,
                        v_trap, v_next, v_haz, v_stall);
                    if (n != 16) begin
                        report_error("an instruction line of the trace is malformed");
                    end else begin
                        instr_cnt++;
                        run_instr();
                    end
                    finish_test($sformatf("instruction pc 0x%08h", v_pc));
                end else if (tag == "R") begin
                    n = $sscanf(trace_lines[i], "%s %h %h", tag, v_rd, v_val);
                    if (n != 3) begin
                        report_error("a register line of the trace is malformed");
                    end else begin
                        read_reg(v_rd[4:0], v_alu);
                        compare_reg(v_rd[4:0], v_alu, v_val);
                    end
                    finish_test($sformatf("register x%0d", v_rd[4:0]));
                end else begin
                    report_error("the trace holds a line of unknown kind");
                    finish_test("trace line");
                end
            end
            if (retire_cnt != instr_cnt) begin
                report_error($sformatf("%0d instructions retired but the trace holds %0d",
                    retire_cnt, instr_cnt));
            end
            finish_test("retirement count");
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/wb_trace.txt ====
# I pc wb_sel rd rf_wen br_flg br_target jmp_flg alu_out csr_rdata mem_rdata is_ecall
#   trap_vector exp_next_pc exp_hazard stall_cycles (all hex except stall_cycles)
# R reg expected_value (hex)
R 02 000003e8
R 00 00000000
R 01 00000000
R 05 00000000
I 00000100 1 05 1 0 00000000 0 11111111 22222222 000080f0 0 00000c00 00000104 0 0
R 05 fffffff0
I 00000104 2 06 1 0 00000000 0 11111111 22222222 000080f0 0 00000c00 00000108 0 0
R 06 000000f0
I 00000108 3 07 1 0 00000000 0 11111111 22222222 000080f0 0 00000c00 0000010c 0 0
R 07 ffff80f0
I 0000010c 4 08 1 0 00000000 0 11111111 22222222 000080f0 0 00000c00 00000110 0 0
R 08 000080f0
I 00000110 5 09 1 0 00000000 0 11111111 22222222 12348765 0 00000c00 00000114 0 0
R 09 12348765
I 00000114 6 0a 1 0 00000000 0 11111111 22222222 000080f0 0 00000c00 00000118 0 0
R 0a 00000118
I 00000118 7 0b 1 0 00000000 0 11111111 22222222 000080f0 0 00000c00 0000011c 0 0
R 0b 22222222
I 0000011c 0 0c 1 0 00000000 0 11111111 22222222 000080f0 0 00000c00 00000120 0 0
R 0c 11111111
I 00000200 0 10 0 0 00000a00 0 00000b00 22222222 000080f0 1 00000c00 00000c00 1 0
I 00000204 6 0d 1 0 00000a00 1 00000b00 22222222 000080f0 0 00000c00 00000b00 1 0
R 0d 00000208
I 00000208 0 10 0 0 00000a00 1 00000b00 22222222 000080f0 1 00000c00 00000b00 1 0
I 0000020c 0 10 0 1 00000a00 0 00000b00 22222222 000080f0 0 00000c00 00000a00 1 0
I 00000210 0 10 0 1 00000a00 0 00000b00 22222222 000080f0 1 00000c00 00000a00 1 0
I 00000214 0 10 0 1 00000a00 1 00000b00 22222222 000080f0 0 00000c00 00000a00 1 0
I 00000218 0 10 0 1 00000a00 1 00000b00 22222222 000080f0 1 00000c00 00000a00 1 0
R 10 00000000
I 00000300 0 05 0 0 00000000 0 deadbeef 22222222 000080f0 0 00000c00 00000304 0 0
R 05 fffffff0
I 00000304 0 00 1 0 00000000 0 deadbeef 22222222 000080f0 0 00000c00 00000308 0 0
R 00 00000000
R 02 000003e8
I 00000400 0 0e 1 0 00000000 0 0000abcd 22222222 000080f0 0 00000c00 00000404 0 4
R 0e 0000abcd
I 00000404 0 0f 1 1 00000800 0 5555aaaa 22222222 000080f0 0 00000c00 00000800 1 6
R 0f 5555aaaa
I 00000800 3 05 1 0 00000000 0 11111111 22222222 0000f001 0 00000c00 00000804 0 3
R 05 fffff001

// ==== compile.f ====
logic/core_pkg.sv
logic/wb_input_latch.sv
logic/wb_stage.sv
logic/reg_file.sv
logic/writeback_top.sv
dv/tb_writeback_top.sv
